/* logic/stream_pkg.sv */
// ----------------------------------------------------------------------
// output stream definitions shared by the buffers and the combiner
// ----------------------------------------------------------------------

package stream_pkg;

	localparam int unsigned WORD_W = 32;    // sample and output word width
	localparam int unsigned CHAN_W = 8;     // channel number field
	localparam int unsigned SEQ_W  = 16;    // per channel frame count

	typedef logic [WORD_W-1:0] word_t;      // one data word
	typedef logic [CHAN_W-1:0] chan_id_t;   // channel number in a header
	typedef logic [SEQ_W-1:0]  seq_t;       // frame sequence count

	localparam logic [7:0] FRAME_TAG = 8'hA5;  // marks every header word

	// header word, msb first
	typedef struct packed
	{
		logic [7:0] tag;    // always FRAME_TAG
		chan_id_t   chan;   // source channel
		seq_t       seq;    // frame number of that channel
	} frame_hdr_t;

	// one output word, read either raw or as a header
	// payload and crc words go through raw, the first word through hdr
	typedef union packed
	{
		word_t      raw;    // payload or crc trailer
		frame_hdr_t hdr;    // frame header
	} out_word_u;

endpackage

/* logic/crc_pkg.sv */
// ----------------------------------------------------------------------
// block crc, crc-32/bzip2 style (non reflected)
// ----------------------------------------------------------------------

package crc_pkg;

	localparam int unsigned CRC_W = 32;      // crc register width

	typedef logic [CRC_W-1:0] crc_t;         // crc value

	localparam crc_t CRC_POLY   = 32'h04C11DB7;  // generator, x^32 implied
	localparam crc_t CRC_INIT   = 32'hFFFFFFFF;  // start of each block
	localparam crc_t CRC_XOROUT = 32'hFFFFFFFF;  // applied at block end

	// advance crc by one data word, msb enters first
	// same result as feeding the word as four big-endian bytes
	function automatic crc_t crc_word(input crc_t crc, input stream_pkg::word_t data);
		crc_t c;
		c = crc;
		for (int i = stream_pkg::WORD_W - 1; i >= 0; i--)
		begin
			if (c[CRC_W-1] ^ data[i])
				c = {c[CRC_W-2:0], 1'b0} ^ CRC_POLY;  // feedback bit set
			else
				c = {c[CRC_W-2:0], 1'b0};             // plain shift
		end
		return c;
	endfunction

endpackage

/* logic/chan_if.sv */
`timescale 1ns/1ps

// one channel buffer towards the frame combiner, show-ahead
interface chan_if #(
	parameter int unsigned BLOCK_WORDS = 8
);

	logic              block_avail;  // a complete block is waiting
	stream_pkg::word_t data;         // oldest buffered word
	crc_pkg::crc_t     crc;          // final crc of oldest block
	logic              pop;          // data taken this cycle
	logic              block_done;   // oldest block sent, retire its crc

	// true on the word index that closes a block
	function automatic logic block_end(input int unsigned idx);
		return idx == BLOCK_WORDS - 1;
	endfunction

	modport channel (
		output block_avail, data, crc,
		input  pop, block_done,
		import block_end
	);

	modport combiner (
		input  block_avail, data, crc,
		output pop, block_done
	);

endinterface

/* logic/channel_block.sv */
`timescale 1ns/1ps

module channel_block #(
	parameter int unsigned BLOCK_WORDS    = 8,
	parameter int unsigned BUF_DEPTH_LOG2 = 5
) (
	input  logic              clk_125,
	input  logic              rst_crc,
	input  stream_pkg::word_t wr_data,
	input  logic              wr,
	output logic              ovf,
	chan_if.channel           chan
);

	localparam int unsigned DEPTH = 1 << BUF_DEPTH_LOG2;                     // buffer words
	localparam int unsigned IDX_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
	// complete blocks in flight, one extra for the block being retired
	localparam int unsigned CQ_LOG2 = $clog2(DEPTH / BLOCK_WORDS + 1);

	// ------------------------------------------------------------------
	// word buffer
	// ------------------------------------------------------------------
	stream_pkg::word_t       buf_mem [DEPTH];  // circular sample store
	logic [BUF_DEPTH_LOG2:0] wr_ptr;           // msb is the wrap bit
	logic [BUF_DEPTH_LOG2:0] rd_ptr;
	logic                    full;
	logic                    store;            // write accepted

	// ------------------------------------------------------------------
	// block counting and crc
	// ------------------------------------------------------------------
	logic [IDX_W-1:0] word_idx;                // position inside block
	logic             blk_last;                // this write closes a block
	crc_pkg::crc_t    crc_run;                 // running crc of open block
	crc_pkg::crc_t    crc_nxt;

	crc_pkg::crc_t    cq_mem [1 << CQ_LOG2];   // final crc per complete block
	logic [CQ_LOG2:0] cq_wr;
	logic [CQ_LOG2:0] cq_rd;

	assign full = (wr_ptr[BUF_DEPTH_LOG2] != rd_ptr[BUF_DEPTH_LOG2]) &&
		(wr_ptr[BUF_DEPTH_LOG2-1:0] == rd_ptr[BUF_DEPTH_LOG2-1:0]);
	assign store    = wr && !full;                        // full buffer drops the word
	assign blk_last = chan.block_end(32'(word_idx));
	assign crc_nxt  = crc_pkg::crc_word(crc_run, wr_data);

	always_ff @(posedge clk_125)
	begin
		if (store)
			buf_mem[wr_ptr[BUF_DEPTH_LOG2-1:0]] <= wr_data;
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (store)
				wr_ptr <= wr_ptr + 1'b1;
			if (chan.pop)
				rd_ptr <= rd_ptr + 1'b1;     // combiner only pops buffered words
		end
	end

	// crc over stored words, pushed at each block boundary
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			word_idx <= '0;
			crc_run  <= crc_pkg::CRC_INIT;
			cq_wr    <= '0;
		end
		else if (store)
		begin
			if (blk_last)
			begin
				word_idx <= '0;
				crc_run  <= crc_pkg::CRC_INIT;  // fresh start for next block
				cq_wr    <= cq_wr + 1'b1;       // block visible next cycle
			end
			else
			begin
				word_idx <= word_idx + 1'b1;
				crc_run  <= crc_nxt;
			end
		end
	end

	always_ff @(posedge clk_125)
	begin
		if (store && blk_last)
			cq_mem[cq_wr[CQ_LOG2-1:0]] <= crc_nxt ^ crc_pkg::CRC_XOROUT;
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			cq_rd <= '0;
		else if (chan.block_done)
			cq_rd <= cq_rd + 1'b1;           // trailer sent, drop its crc
	end

	// sticky overflow, only reset clears it
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			ovf <= 1'b0;
		else if (wr && full)
			ovf <= 1'b1;
	end

	assign chan.block_avail = cq_wr != cq_rd;
	assign chan.data        = buf_mem[rd_ptr[BUF_DEPTH_LOG2-1:0]];  // show-ahead
	assign chan.crc         = cq_mem[cq_rd[CQ_LOG2-1:0]];

endmodule

/* logic/frame_combiner.sv */
`timescale 1ns/1ps

module frame_combiner #(
	parameter int unsigned BLOCK_WORDS = 8,
	parameter int unsigned CREDITS     = 4
) (
	input  logic                  clk_125,
	input  logic                  rst_crc,
	input  logic                  time_clr,
	input  logic                  credit_return,
	chan_if.combiner              ch0,
	chan_if.combiner              ch1,
	output stream_pkg::out_word_u out_data,
	output logic                  out_valid,
	output logic                  out_sop,
	output logic                  out_eop
);

	localparam int unsigned CNT_W  = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
	localparam int unsigned CRED_W = $clog2(CREDITS + 1);

	localparam stream_pkg::chan_id_t CH0_ID = 8'd0;  // header channel numbers
	localparam stream_pkg::chan_id_t CH1_ID = 8'd1;

	typedef enum logic [1:0]
	{
		ST_IDLE,   // waiting for a complete block
		ST_HDR,    // header word
		ST_PAY,    // payload words
		ST_CRC     // crc trailer
	} state_t;

	state_t            state;
	logic              sel;        // channel of current frame
	logic              last_sel;   // channel of previous frame
	logic              pick;       // round-robin choice in idle
	logic [CNT_W-1:0]  pay_cnt;    // payload word index
	stream_pkg::seq_t  seq0;       // frame counts per channel
	stream_pkg::seq_t  seq1;
	logic [CRED_W-1:0] credits;    // words the sink can still take

	// ------------------------------------------------------------------
	// channel choice and frame FSM
	// ------------------------------------------------------------------
	always_comb
	begin
		if (ch0.block_avail && ch1.block_avail)
			pick = ~last_sel;          // both ready, alternate
		else
			pick = ch1.block_avail;    // only one ready
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			state    <= ST_IDLE;
			sel      <= 1'b0;
			last_sel <= 1'b1;          // channel 0 wins the first tie
			pay_cnt  <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (ch0.block_avail || ch1.block_avail)
					begin
						sel   <= pick;
						state <= ST_HDR;
					end
				ST_HDR:
					if (out_valid)
					begin
						pay_cnt <= '0;
						state   <= ST_PAY;
					end
				ST_PAY:
					if (out_valid)
					begin
						if (pay_cnt == CNT_W'(BLOCK_WORDS - 1))
							state <= ST_CRC;
						else
							pay_cnt <= pay_cnt + 1'b1;
					end
				default:
					if (out_valid)
					begin
						last_sel <= sel;
						state    <= ST_IDLE;
					end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// sequence counts and output credits
	// ------------------------------------------------------------------
	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
		begin
			seq0 <= '0;
			seq1 <= '0;
		end
		else if (time_clr)
		begin
			seq0 <= '0;                // next unsent header starts at 0
			seq1 <= '0;
		end
		else if (out_sop)
		begin
			if (sel)
				seq1 <= seq1 + 1'b1;
			else
				seq0 <= seq0 + 1'b1;
		end
	end

	always_ff @(posedge clk_125)
	begin
		if (rst_crc)
			credits <= CRED_W'(CREDITS);
		else
		begin
			case ({out_valid, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;       // none or both
			endcase
		end
	end

	// word goes out whenever a frame is open and a credit is left
	assign out_valid = (state != ST_IDLE) && (credits != '0);
	assign out_sop   = out_valid && (state == ST_HDR);
	assign out_eop   = out_valid && (state == ST_CRC);

	assign ch0.pop        = out_valid && (state == ST_PAY) && !sel;
	assign ch1.pop        = out_valid && (state == ST_PAY) && sel;
	assign ch0.block_done = out_eop && !sel;
	assign ch1.block_done = out_eop && sel;

	always_comb
	begin
		out_data = '0;
		case (state)
			ST_HDR:
			begin
				out_data.hdr.tag  = stream_pkg::FRAME_TAG;
				out_data.hdr.chan = sel ? CH1_ID : CH0_ID;
				out_data.hdr.seq  = sel ? seq1 : seq0;
			end
			ST_PAY:  out_data.raw = sel ? ch1.data : ch0.data;
			ST_CRC:  out_data.raw = sel ? ch1.crc : ch0.crc;
			default: out_data.raw = '0;
		endcase
	end

endmodule

/* logic/block_stream_top.sv */
`timescale 1ns/1ps

module block_stream_top #(
	parameter int unsigned BLOCK_WORDS    = 8,   // payload words per frame
	parameter int unsigned BUF_DEPTH_LOG2 = 5,   // per channel buffer, two blocks min
	parameter int unsigned CREDITS        = 4    // sink credits after reset
) (
	input  logic              clk_125,
	input  logic              rst_crc,
	input  stream_pkg::word_t in0_data,
	input  logic              in0_wr,
	input  stream_pkg::word_t in1_data,
	input  logic              in1_wr,
	input  logic              time_clr,
	input  logic              credit_return,
	output stream_pkg::word_t out_data,
	output logic              out_valid,
	output logic              out_sop,
	output logic              out_eop,
	output logic              ovf0,
	output logic              ovf1
);

	// ------------------------------------------------------------------
	// channel buffers
	// ------------------------------------------------------------------
	chan_if #(.BLOCK_WORDS(BLOCK_WORDS)) ch0_if ();
	chan_if #(.BLOCK_WORDS(BLOCK_WORDS)) ch1_if ();

	channel_block #(
		.BLOCK_WORDS    (BLOCK_WORDS),
		.BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
	) u_ch0 (
		.clk_125 (clk_125),
		.rst_crc (rst_crc),
		.wr_data (in0_data),
		.wr      (in0_wr),
		.ovf     (ovf0),
		.chan    (ch0_if)
	);

	channel_block #(
		.BLOCK_WORDS    (BLOCK_WORDS),
		.BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
	) u_ch1 (
		.clk_125 (clk_125),
		.rst_crc (rst_crc),
		.wr_data (in1_data),
		.wr      (in1_wr),
		.ovf     (ovf1),
		.chan    (ch1_if)
	);

	// ------------------------------------------------------------------
	// framing towards the sink
	// ------------------------------------------------------------------
	frame_combiner #(
		.BLOCK_WORDS (BLOCK_WORDS),
		.CREDITS     (CREDITS)
	) u_comb (
		.clk_125       (clk_125),
		.rst_crc       (rst_crc),
		.time_clr      (time_clr),
		.credit_return (credit_return),
		.ch0           (ch0_if),
		.ch1           (ch1_if),
		.out_data      (out_data),       // union seen as a plain word here
		.out_valid     (out_valid),
		.out_sop       (out_sop),
		.out_eop       (out_eop)
	);

endmodule

/* bench/tb_block_stream.sv */
`timescale 1ns/1ps

module tb_block_stream;

	localparam int BLOCK_WORDS    = 8;
	localparam int BUF_DEPTH_LOG2 = 5;
	localparam int CREDITS        = 4;
	localparam int DEPTH          = 1 << BUF_DEPTH_LOG2;
	localparam int MAX_CYCLES     = 4000;    // full run takes a few hundred

	logic              clk_125;
	logic              rst_crc;
	stream_pkg::word_t in0_data;
	logic              in0_wr;
	stream_pkg::word_t in1_data;
	logic              in1_wr;
	logic              time_clr;
	logic              credit_return;
	stream_pkg::word_t out_data;
	logic              out_valid;
	logic              out_sop;
	logic              out_eop;
	logic              ovf0;
	logic              ovf1;

	// ------------------------------------------------------------------
	// reference model state
	// ------------------------------------------------------------------
	stream_pkg::word_t exp_q0 [$];           // words still owed by channel 0
	stream_pkg::word_t exp_q1 [$];           // same for channel 1
	stream_pkg::seq_t  seq [2];              // next header count per channel
	int                written [2];          // words written per channel
	int                sent [2];             // frames finished per channel
	int                pos;                  // word index inside frame
	logic              cur;                  // channel of open frame
	logic              last_ch;              // channel of previous frame
	logic              both_ready;           // tie seen when last frame ended
	crc_pkg::crc_t     run_crc;
	int                held;                 // words taken, credit not back yet
	logic              stall;                // holds credit returns off
	integer            seed;
	int                cycles;

	block_stream_top #(
		.BLOCK_WORDS    (BLOCK_WORDS),
		.BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2),
		.CREDITS        (CREDITS)
	) DUT (.*);

	always #20 clk_125 = ~clk_125;           // 40 ns period

	// crc-32/bzip2 fed one big-endian byte at a time
	function automatic crc_pkg::crc_t crc_add(input crc_pkg::crc_t crc,
		input stream_pkg::word_t w);
		crc_pkg::crc_t c;
		logic [7:0]    b;
		c = crc;
		for (int k = 3; k >= 0; k--)
		begin
			b = w[8*k +: 8];
			c = c ^ {b, 24'h0};                  // byte into top of register
			for (int j = 0; j < 8; j++)
				c = c[31] ? ((c << 1) ^ crc_pkg::CRC_POLY) : (c << 1);
		end
		return c;
	endfunction

	function automatic int ready_blocks(input logic ch);
		return written[ch] / BLOCK_WORDS - sent[ch];  // complete blocks not yet framed
	endfunction

	task automatic value_error(input string msg);
		$display("** Error @ %0t ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic tick();
		@(posedge clk_125);
		#2;                                  // drive point after the edge
	endtask

	task automatic do_reset();
		rst_crc = 1'b1;
		repeat (2) tick();
		rst_crc = 1'b0;
	endtask

	task automatic set_stall(input logic on);
		@(negedge clk_125);
		stall = on;                          // away from credit drive point
		tick();
	endtask

	task automatic clear_model();
		exp_q0.delete();
		exp_q1.delete();
		seq        = '{default: '0};
		written    = '{default: 0};
		sent       = '{default: 0};
		pos        = 0;
		cur        = 1'b0;
		last_ch    = 1'b1;
		both_ready = 1'b0;
		held       = 0;
	endtask

	// one write per cycle on the chosen channels
	task automatic drive_writes(input int count, input logic use0, input logic use1);
		for (int i = 0; i < count; i++)
		begin
			tick();
			in0_wr = use0;
			in1_wr = use1;
			if (use0)
			begin
				in0_data = $random(seed);
				exp_q0.push_back(in0_data);
				written[0] = written[0] + 1;
			end
			if (use1)
			begin
				in1_data = $random(seed);
				exp_q1.push_back(in1_data);
				written[1] = written[1] + 1;
			end
		end
		tick();
		in0_wr = 1'b0;
		in1_wr = 1'b0;
	endtask

	task automatic wait_drained();
		@(posedge clk_125);
		while (exp_q0.size() != 0 || exp_q1.size() != 0 || pos != 0)
			@(posedge clk_125);              // model empty and no frame open
	endtask

	task automatic check_word();
		stream_pkg::frame_hdr_t hdr;
		stream_pkg::word_t      exp_w;
		hdr = out_data;
		assert (held < CREDITS) else value_error("word sent with no credit left");
		if (pos == 0)
		begin
			assert (out_sop && !out_eop) else value_error("markers wrong on header");
			assert (hdr.tag == stream_pkg::FRAME_TAG)
				else value_error($sformatf("frame tag %h", hdr.tag));
			assert (hdr.chan <= 8'd1)
				else value_error($sformatf("channel %0d in header", hdr.chan));
			cur = hdr.chan[0];
			assert (ready_blocks(cur) > 0) else value_error("header with no complete block");
			assert (!both_ready || cur != last_ch) else value_error("round-robin order broken");
			assert (hdr.seq == seq[cur])
				else value_error($sformatf("ch%0d seq %0d, expected %0d", cur, hdr.seq, seq[cur]));
			seq[cur] = seq[cur] + 1'b1;
			run_crc  = crc_pkg::CRC_INIT;
		end
		else if (pos <= BLOCK_WORDS)
		begin
			assert (!out_sop && !out_eop) else value_error("marker on payload word");
			exp_w = cur ? exp_q1.pop_front() : exp_q0.pop_front();
			assert (out_data == exp_w)
				else value_error($sformatf("ch%0d payload %h, expected %h", cur, out_data, exp_w));
			run_crc = crc_add(run_crc, exp_w);
		end
		else
		begin
			assert (out_eop && !out_sop) else value_error("markers wrong on crc word");
			exp_w = run_crc ^ crc_pkg::CRC_XOROUT;
			assert (out_data == exp_w)
				else value_error($sformatf("ch%0d crc %h, expected %h", cur, out_data, exp_w));
			sent[cur]  = sent[cur] + 1;
			last_ch    = cur;
			both_ready = ready_blocks(1'b0) > 0 && ready_blocks(1'b1) > 0;  // next pick
		end
		pos = (pos == BLOCK_WORDS + 1) ? 0 : pos + 1;
	endtask

	// ------------------------------------------------------------------
	// monitor, credit sink and cycle limit
	// ------------------------------------------------------------------
	always @(negedge clk_125)
	begin
		if (rst_crc)
			clear_model();
		else
		begin
			if (out_valid)
				check_word();
			else
				assert (!out_sop && !out_eop) else value_error("marker without valid");
			if (out_valid)
				held = held + 1;
			if (credit_return)
				held = held - 1;
			if (time_clr)
				seq = '{default: '0};        // header in this cycle kept old count
		end
	end

	always @(posedge clk_125)
	begin
		#2;
		credit_return = !stall && held > 0;  // one credit back per cycle
	end

	always @(posedge clk_125)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial
	begin
		seed          = 32'h8af200d4;
		clk_125       = 1'b0;
		rst_crc       = 1'b1;
		in0_data      = '0;
		in0_wr        = 1'b0;
		in1_data      = '0;
		in1_wr        = 1'b0;
		time_clr      = 1'b0;
		credit_return = 1'b0;
		stall         = 1'b0;
		cycles        = 0;
		clear_model();
		do_reset();
		assert (!out_valid && !ovf0 && !ovf1) else value_error("outputs busy after reset");

		drive_writes(BLOCK_WORDS, 1'b1, 1'b0);         // single channel 0 frame
		wait_drained();

		drive_writes(3 * BLOCK_WORDS, 1'b1, 1'b1);     // three blocks on both channels
		wait_drained();

		set_stall(1'b1);                               // sink stops returning credits
		drive_writes(2 * BLOCK_WORDS, 1'b1, 1'b1);
		while (held < CREDITS)
			@(posedge clk_125);
		repeat (10) tick();                            // nothing may leave here
		set_stall(1'b0);
		wait_drained();

		tick();
		time_clr = 1'b1;                               // between frames
		tick();
		time_clr = 1'b0;
		drive_writes(BLOCK_WORDS, 1'b1, 1'b1);
		wait_drained();

		// channel 0 overflow while the combiner drains at most CREDITS words
		set_stall(1'b1);
		do_reset();
		drive_writes(DEPTH, 1'b1, 1'b0);
		assert (!ovf0) else value_error("overflow flagged with room left");
		drive_writes(CREDITS + 1, 1'b1, 1'b0);
		assert (ovf0 && !ovf1) else value_error("overflow not flagged on channel 0");
		repeat (8)
		begin
			tick();
			assert (ovf0) else value_error("overflow flag dropped before reset");
		end
		do_reset();
		assert (!ovf0) else value_error("reset left overflow set");

		$display("test passed");
		$finish;
	end

endmodule

/* list.f */
logic/stream_pkg.sv
logic/crc_pkg.sv
logic/chan_if.sv
logic/channel_block.sv
logic/frame_combiner.sv
logic/block_stream_top.sv
bench/tb_block_stream.sv

/* run_sim.sh */
#!/bin/sh
# build and run the block stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_block_stream -o tb_block_stream
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_block_stream 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass message not found"
exit 1
